/* alu.sv */
`timescale 1ns/1ps

module alu import riscv_core_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    cmp_flag
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Only the low five bits count for shifts
    assign shamt = b[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = word_t'(lt_signed);
            ALU_SLTU: result = word_t'(lt_unsigned);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // Branch condition for the decoder
    always_comb begin
        case (alu_op)
            ALU_SUB: begin
                // Zero flag, for BEQ/BNE
                cmp_flag = (result == '0);
            end
            ALU_SLT, ALU_SLTU: begin
                cmp_flag = result[0];
            end
            default: begin
                cmp_flag = 1'b0;
            end
        endcase
    end

endmodule

/* ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if import riscv_core_pkg::*; ();

    alu_op_t   alu_op;
    imm_kind_t imm_kind;
    logic      src1_is_pc;
    logic      src2_is_imm;
    pc_src_t   pc_src;
    wb_src_t   wb_src;
    logic      reg_write;
    logic      mem_write;

    modport decoder (
        output alu_op, imm_kind, src1_is_pc, src2_is_imm,
        output pc_src, wb_src, reg_write, mem_write
    );

    modport datapath (
        input alu_op, imm_kind, src1_is_pc, src2_is_imm,
        input pc_src, wb_src, reg_write, mem_write
    );

endinterface

/* imm_gen.sv */
`timescale 1ns/1ps
`include "riscv_core_consts.svh"

module imm_gen import riscv_core_pkg::*; (
    input  word_t     instr,
    input  imm_kind_t imm_kind,
    output word_t     imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_kind)
            IMM_I: begin
                imm = {{(`XLEN-12){sign}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // Offset in halfwords, bit 0 always zero
                imm = {{(`XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{(`XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import riscv_core_pkg::*; (
    input  word_t      instr,
    input  logic       cmp_flag,
    ctrl_if.decoder    ctrl
);

    opcode_t   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd;
    logic      is_branch;
    logic      branch_taken;
    logic      reg_write_raw;
    pc_src_t   pc_src_base;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // Shared by OP and OP_IMM where alt picks SUB or SRA
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl.alu_op      = ALU_ADD;
        ctrl.imm_kind    = IMM_I;
        ctrl.src1_is_pc  = 1'b0;
        ctrl.src2_is_imm = 1'b0;
        ctrl.wb_src      = WB_ALU;
        ctrl.mem_write   = 1'b0;
        reg_write_raw    = 1'b0;
        pc_src_base      = PC_SEQ;
        is_branch        = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.wb_src      = WB_MEM;
                reg_write_raw    = 1'b1;
            end
            OPC_OP_IMM: begin
                // funct7 only matters for the right shifts here
                ctrl.alu_op      = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
                ctrl.src2_is_imm = 1'b1;
                reg_write_raw    = 1'b1;
            end
            OPC_STORE: begin
                ctrl.imm_kind    = IMM_S;
                ctrl.src2_is_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_op   = arith_op(funct3, funct7[5]);
                reg_write_raw = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.imm_kind = IMM_B;
                is_branch     = 1'b1;
                case (funct3[2:1])
                    2'b10:   ctrl.alu_op = ALU_SLT;
                    2'b11:   ctrl.alu_op = ALU_SLTU;
                    default: ctrl.alu_op = ALU_SUB;
                endcase
            end
            OPC_JAL: begin
                ctrl.imm_kind = IMM_J;
                ctrl.wb_src   = WB_LINK;
                pc_src_base   = PC_TARGET;
                reg_write_raw = 1'b1;
            end
            OPC_JALR: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.wb_src      = WB_LINK;
                pc_src_base      = PC_JUMP_REG;
                reg_write_raw    = 1'b1;
            end
            OPC_LUI: begin
                ctrl.imm_kind = IMM_U;
                ctrl.wb_src   = WB_IMM;
                reg_write_raw = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.imm_kind    = IMM_U;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                reg_write_raw    = 1'b1;
            end
            default: begin
                // Unknown opcode retires as a no-op
                reg_write_raw = 1'b0;
                pc_src_base   = PC_SEQ;
            end
        endcase
    end

    // funct3[0] inverts the sense for BNE, BGE and BGEU
    assign branch_taken = funct3[0] ^ cmp_flag;

    // Kept apart from the case so the ALU flag does not loop back into alu_op
    assign ctrl.pc_src = (is_branch && branch_taken) ? PC_TARGET : pc_src_base;

    // No write to x0
    assign ctrl.reg_write = reg_write_raw && (rd != '0);

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "riscv_core_consts.svh"

module reg_file import riscv_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      write_en,
    input  reg_addr_t rd_addr,
    input  word_t     rd_value,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_value,
    output word_t     rs2_value
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[rd_addr] <= rd_value;
        end
    end

    // x0 always reads zero
    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Decoder is expected to drop writes to x0
    assert property (@(posedge clk) disable iff (reset) write_en |-> (rd_addr != '0))
        else $error("register write reached x0");

endmodule

/* riscv_core.f */
+incdir+.
riscv_core_pkg.sv
ctrl_if.sv
instr_decoder.sv
imm_gen.sv
alu.sv
reg_file.sv
riscv_core.sv
tb_riscv_core.sv

/* riscv_core.sv */
`timescale 1ns/1ps
`include "riscv_core_consts.svh"

module riscv_core import riscv_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t instr,
    input  word_t rd_data,
    output word_t pc,
    output word_t addr,
    output word_t wr_data,
    output logic  wr_en
);

    ctrl_if ctrl ();

    word_t pc_next;
    word_t pc_plus_step;
    word_t pc_target;
    word_t imm;
    word_t rs1_value;
    word_t rs2_value;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t wb_value;
    logic  cmp_flag;

    instr_decoder u_decoder (
        .instr    (instr),
        .cmp_flag (cmp_flag),
        .ctrl     (ctrl.decoder)
    );

    imm_gen u_imm_gen (
        .instr    (instr),
        .imm_kind (ctrl.imm_kind),
        .imm      (imm)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset     (reset),
        .write_en  (ctrl.reg_write && !reset),
        .rd_addr   (instr[11:7]),
        .rd_value  (wb_value),
        .rs1_addr  (instr[19:15]),
        .rs2_addr  (instr[24:20]),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    // Operand select
    assign alu_a = ctrl.src1_is_pc  ? pc  : rs1_value;
    assign alu_b = ctrl.src2_is_imm ? imm : rs2_value;

    alu u_alu (
        .alu_op   (ctrl.alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_result),
        .cmp_flag (cmp_flag)
    );

    assign pc_plus_step = pc + `PC_STEP;
    assign pc_target    = pc + imm;

    always_comb begin
        case (ctrl.pc_src)
            PC_TARGET:   pc_next = pc_target;
            // JALR clears bit 0 of the computed target
            PC_JUMP_REG: pc_next = {alu_result[`XLEN-1:1], 1'b0};
            default:     pc_next = pc_plus_step;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Write-back select
    always_comb begin
        case (ctrl.wb_src)
            WB_MEM:  wb_value = rd_data;
            WB_LINK: wb_value = pc_plus_step;
            WB_IMM:  wb_value = imm;
            default: wb_value = alu_result;
        endcase
    end

    // Word memory, low address bits dropped
    assign addr    = {alu_result[`XLEN-1:2], 2'b00};
    assign wr_data = rs2_value;
    assign wr_en   = ctrl.mem_write && !reset;

    // Branch and jump offsets in the program must keep pc word aligned
    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

/* riscv_core_consts.svh */
`ifndef RISCV_CORE_CONSTS_SVH
`define RISCV_CORE_CONSTS_SVH

// Data and address width
`define XLEN 32

// Integer register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

// Program counter
`define RESET_PC 32'h0000_0000
`define PC_STEP 32'd4

`endif

/* riscv_core_pkg.sv */
`include "riscv_core_consts.svh"

package riscv_core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_kind_t;

    typedef enum logic [1:0] {
        PC_SEQ      = 2'd0,
        PC_TARGET   = 2'd1,
        PC_JUMP_REG = 2'd2
    } pc_src_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2,
        WB_IMM  = 2'd3
    } wb_src_t;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

# Build the simulation model, assertions enabled
verilator --binary --timing --assert -f riscv_core.f --top-module tb_riscv_core -o sim_riscv_core

# A $fatal in the testbench gives a failing exit status
./obj_dir/sim_riscv_core

/* tb_riscv_core.sv */
`timescale 1ns/1ps
`include "riscv_core_consts.svh"

module tb_riscv_core import riscv_core_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 1024;
    localparam word_t SLOT_BASE = 32'h0000_0100;
    localparam word_t FORBID_ADDR = 32'h0000_07F0;
    localparam word_t SENTINEL_ADDR = 32'h0000_07F8;
    localparam word_t SENTINEL_VALUE = 32'h5A5A_C3C3;

    logic  clk = 1'b0;
    logic  reset;
    word_t instr;
    word_t rd_data;
    word_t pc;
    word_t addr;
    word_t wr_data;
    logic  wr_en;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    // Expected behavior of the instruction at each word of the program
    word_t exp_next [IMEM_WORDS];
    word_t exp_addr [IMEM_WORDS];
    word_t exp_data [IMEM_WORDS];
    logic  store_ok [IMEM_WORDS];
    word_t rf [`REG_COUNT];
    int    prog_len = 0;
    word_t next_slot = SLOT_BASE;
    logic  prog_built = 1'b0;

    logic       was_reset = 1'b0;
    logic       prev_retired = 1'b0;
    word_t      pc_prev;
    word_t      instr_prev;
    word_t      exp_next_prev;
    logic [7:0] pc_idx;

    riscv_core u_dut (
        .clk     (clk),
        .reset   (reset),
        .instr   (instr),
        .rd_data (rd_data),
        .pc      (pc),
        .addr    (addr),
        .wr_data (wr_data),
        .wr_en   (wr_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories answer combinationally
    assign pc_idx  = pc[9:2];
    assign instr   = imem[pc_idx];
    assign rd_data = dmem[addr[11:2]];

    always @(posedge clk) begin
        if (wr_en) begin
            dmem[addr[11:2]] <= wr_data;
        end
        was_reset     <= reset;
        prev_retired  <= !reset;
        pc_prev       <= pc;
        instr_prev    <= instr;
        exp_next_prev <= exp_next[pc_idx];
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic logic is_transfer(input word_t w);
        return w[6:0] == OPC_BRANCH || w[6:0] == OPC_JAL || w[6:0] == OPC_JALR;
    endfunction

    function automatic word_t addr_of(input int idx);
        return `RESET_PC + word_t'(idx) * `PC_STEP;
    endfunction

    function automatic word_t rr(input logic alt, input logic [2:0] f3);
        return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len]     = w;
        exp_next[prog_len] = addr_of(prog_len + 1);
        store_ok[prog_len] = 1'b0;
        prog_len++;
    endtask

    // x0 stays zero whatever is written to it
    task automatic set_reg(input reg_addr_t rd, input word_t value);
        if (rd != 5'd0) begin
            rf[rd] = value;
        end
    endtask

    task automatic store_word(input reg_addr_t rs2, input word_t slot);
        exp_addr[prog_len] = slot;
        exp_data[prog_len] = rf[rs2];
        emit(enc_s(slot[11:0], rs2));
        store_ok[prog_len - 1] = 1'b1;
    endtask

    task automatic store_check(input reg_addr_t rs2);
        store_word(rs2, next_slot);
        next_slot = next_slot + 32'd4;
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t value);
        word_t upper;
        // ADDI sign-extends, so round the upper part
        upper = value + 32'h800;
        emit(enc_u(upper[31:12], rd));
        emit(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
        set_reg(rd, value);
    endtask

    task automatic alu_case(input word_t w, input word_t expected);
        emit(w);
        set_reg(5'd3, expected);
        store_check(5'd3);
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2);
        logic  taken;
        word_t x;
        word_t y;
        int    br_idx;
        x = rf[rs1];
        y = rf[rs2];
        case (f3)
            3'b000:  taken = (x == y);
            3'b001:  taken = (x != y);
            3'b100:  taken = ($signed(x) < $signed(y));
            3'b101:  taken = ($signed(x) >= $signed(y));
            3'b110:  taken = (x < y);
            default: taken = (x >= y);
        endcase
        br_idx = prog_len;
        emit(enc_b(13'd8, rs2, rs1, f3));
        if (taken) begin
            exp_next[br_idx] = addr_of(br_idx + 2);
        end else begin
            // Fall-through hops over the target word
            emit(enc_j(21'd8, 5'd0));
            exp_next[br_idx + 1] = addr_of(br_idx + 3);
        end
        emit(enc_s(FORBID_ADDR[11:0], 5'd1));
    endtask

    task automatic build_program();
        word_t       a;
        word_t       b;
        word_t       immv;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [2:0]  f3;
        int          j;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {i[24:0], 7'b1111111};
        end
        foreach (rf[i]) begin
            rf[i] = '0;
        end
        a = $urandom;
        b = $urandom;
        imm = 12'($urandom);
        sh = 5'($urandom);
        immv = {{20{imm[11]}}, imm};
        load_const(5'd1, a);
        load_const(5'd2, b);
        alu_case(rr(1'b0, 3'b000), a + b);
        alu_case(rr(1'b1, 3'b000), a - b);
        alu_case(rr(1'b0, 3'b001), a << b[4:0]);
        alu_case(rr(1'b0, 3'b010), word_t'($signed(a) < $signed(b)));
        alu_case(rr(1'b0, 3'b011), word_t'(a < b));
        alu_case(rr(1'b0, 3'b100), a ^ b);
        alu_case(rr(1'b0, 3'b101), a >> b[4:0]);
        alu_case(rr(1'b1, 3'b101), word_t'($signed(a) >>> b[4:0]));
        alu_case(rr(1'b0, 3'b110), a | b);
        alu_case(rr(1'b0, 3'b111), a & b);
        alu_case(enc_i(imm, 5'd1, 3'b000, 5'd3, OPC_OP_IMM), a + immv);
        alu_case(enc_i(imm, 5'd1, 3'b010, 5'd3, OPC_OP_IMM), word_t'($signed(a) < $signed(immv)));
        alu_case(enc_i(imm, 5'd1, 3'b011, 5'd3, OPC_OP_IMM), word_t'(a < immv));
        alu_case(enc_i(imm, 5'd1, 3'b100, 5'd3, OPC_OP_IMM), a ^ immv);
        alu_case(enc_i(imm, 5'd1, 3'b110, 5'd3, OPC_OP_IMM), a | immv);
        alu_case(enc_i(imm, 5'd1, 3'b111, 5'd3, OPC_OP_IMM), a & immv);
        alu_case(enc_i({7'b0, sh}, 5'd1, 3'b001, 5'd3, OPC_OP_IMM), a << sh);
        alu_case(enc_i({7'b0, sh}, 5'd1, 3'b101, 5'd3, OPC_OP_IMM), a >> sh);
        alu_case(enc_i({7'b0100000, sh}, 5'd1, 3'b101, 5'd3, OPC_OP_IMM),
                 word_t'($signed(a) >>> sh));
        // Unknown opcodes aimed at x3 must leave it alone
        emit({12'hABC, 5'd1, 3'b000, 5'd3, 7'b0001011});
        emit({12'h123, 5'd2, 3'b111, 5'd3, 7'b1111111});
        store_check(5'd3);
        // SLOT_BASE holds the ADD result
        emit(enc_i(SLOT_BASE[11:0], 5'd0, 3'b010, 5'd4, OPC_LOAD));
        set_reg(5'd4, a + b);
        store_check(5'd4);
        // Opposite signs tell signed and unsigned compares apart
        load_const(5'd1, a | 32'h8000_0000);
        load_const(5'd2, b & 32'h7FFF_FFFF);
        for (int f = 0; f < 8; f++) begin
            f3 = 3'(f);
            if (f3[2]) begin
                branch_case(f3, 5'd1, 5'd2);
                branch_case(f3, 5'd2, 5'd1);
            end else if (!f3[1]) begin
                branch_case(f3, 5'd1, 5'd1);
                branch_case(f3, 5'd1, 5'd2);
            end
        end
        j = prog_len;
        emit(enc_j(21'd8, 5'd6));
        exp_next[j] = addr_of(j + 2);
        set_reg(5'd6, addr_of(j) + `PC_STEP);
        emit(enc_s(FORBID_ADDR[11:0], 5'd1));
        store_check(5'd6);
        // JALR sum is odd and bit 0 must be dropped
        j = prog_len + 2;
        load_const(5'd7, addr_of(j + 2) - 32'd4);
        emit(enc_i(12'd5, 5'd7, 3'b000, 5'd8, OPC_JALR));
        exp_next[j] = (rf[7] + 32'd5) & ~32'd1;
        set_reg(5'd8, addr_of(j) + `PC_STEP);
        emit(enc_s(FORBID_ADDR[11:0], 5'd1));
        store_check(5'd8);
        emit(enc_i(12'd123, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
        store_check(5'd0);
        load_const(5'd10, SENTINEL_VALUE);
        store_word(5'd10, SENTINEL_ADDR);
        j = prog_len;
        emit(enc_j(21'd0, 5'd0));
        exp_next[j] = addr_of(j);
    endtask

    assert property (@(posedge clk) was_reset |-> pc == `RESET_PC)
        else report_fail($sformatf("pc %h after reset, expected %h", pc, `RESET_PC));
    assert property (@(posedge clk) (reset || was_reset) |-> !wr_en)
        else report_fail("wr_en high during or right after reset");
    assert property (@(posedge clk)
        (prev_retired && !is_transfer(instr_prev)) |-> pc == pc_prev + `PC_STEP)
        else report_fail($sformatf("pc %h after %h at %h", pc, instr_prev, pc_prev));
    assert property (@(posedge clk)
        (prev_retired && is_transfer(instr_prev)) |-> pc == exp_next_prev)
        else report_fail($sformatf("pc %h after jump, expected %h", pc, exp_next_prev));
    assert property (@(posedge clk) (!reset && wr_en) |-> store_ok[pc_idx])
        else report_fail($sformatf("unexpected store at pc %h", pc));
    assert property (@(posedge clk) (!reset && wr_en && store_ok[pc_idx])
        |-> (addr == exp_addr[pc_idx] && wr_data == exp_data[pc_idx]))
        else report_fail($sformatf("store %h to %h, expected %h to %h",
                                   wr_data, addr, exp_data[pc_idx], exp_addr[pc_idx]));
    assert property (@(posedge clk) wr_en |-> addr != FORBID_ADDR)
        else report_fail($sformatf("store to skipped slot from pc %h", pc));

    initial begin
        reset = 1'b1;
        void'($urandom(12));
        build_program();
        prog_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        do @(negedge clk); while (!(!reset && wr_en && addr == SENTINEL_ADDR));
        // Let the checks on the final edge run first
        @(posedge clk);
        #1;
        $display(">>> PASS");
        $finish;
    end

    initial begin
        wait (prog_built);
        #((RESET_CYCLES + prog_len + 50) * CLK_PERIOD);
        $display("Timeout: the program never reached its final store");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
